// File: include/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// address and pipeline word
`define DC_ADDR_W    32
`define DC_XLEN      64

// line geometry, 32 bytes per line
`define DC_LINE_W    256
`define DC_SETS      64
`define DC_INDEX_W   6
`define DC_OFFSET_W  5

// what is left of the address above index and offset
`define DC_TAG_W     21

// refill beats of one pipeline word each
`define DC_BEATS     4

`endif

// File: verilog/dcachePkg.sv
`include "dcache_defs.svh"

package dcachePkg;

  typedef logic [`DC_ADDR_W-1:0]   addr_t;
  typedef logic [`DC_XLEN-1:0]     word_t;
  typedef logic [`DC_LINE_W-1:0]   line_t;
  typedef logic [`DC_TAG_W-1:0]    tag_t;
  typedef logic [`DC_INDEX_W-1:0]  index_t;
  typedef logic [`DC_XLEN/8-1:0]   byteMask_t;

  // controller states
  typedef enum logic [2:0] {
    idle,
    lookup,
    writeBack,
    refillReq,
    refillWait,
    install
  } cacheState_e;

  // one load or store from the pipeline
  typedef struct packed {
    logic      isStore;
    addr_t     addr;
    word_t     wrData;
    byteMask_t wrMask;
  } cpuReq_t;

  // line read request, address is line aligned
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } memRdReq_t;

  typedef struct packed {
    logic  valid;
    logic  last;
    word_t data;
  } memRdResp_t;

  // whole line write-back
  typedef struct packed {
    logic  valid;
    addr_t addr;
    line_t data;
  } memWrReq_t;

endpackage

// File: verilog/dcacheTagArray.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcacheTagArray (
  input  logic              clk,
  input  logic              rst_n,
  input  dcachePkg::index_t index_i,
  input  dcachePkg::tag_t   tag_i,
  input  logic              storeWe_i,
  input  logic              installWe_i,
  input  logic              missSeen_i,
  output logic              hit_o,
  output logic              hitWay_o,
  output logic              victimWay_o,
  output dcachePkg::tag_t   victimTag_o,
  output logic              victimDirty_o
);
  import dcachePkg::*;

  tag_t                     tagMem [2][`DC_SETS];
  logic [1:0][`DC_SETS-1:0] validQ;
  logic [1:0][`DC_SETS-1:0] dirtyQ;
  logic                     replBit;
  logic [1:0]               wayHit;

  // compare both ways against the request tag
  for (genvar w = 0; w < 2; w++) begin : gCmp
    assign wayHit[w] = validQ[w][index_i] && (tagMem[w][index_i] == tag_i);
  end

  assign hit_o    = |wayHit;
  assign hitWay_o = wayHit[1];

  // during a lookup miss the victim is already the toggled way
  assign victimWay_o   = replBit ^ missSeen_i;
  assign victimTag_o   = tagMem[victimWay_o][index_i];
  assign victimDirty_o = validQ[victimWay_o][index_i] && dirtyQ[victimWay_o][index_i];

  always_ff @(posedge clk) begin
    if (installWe_i) begin
      tagMem[victimWay_o][index_i] <= tag_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ  <= '0;
      dirtyQ  <= '0;
      replBit <= 1'b0;
    end else begin
      if (missSeen_i) begin
        replBit <= ~replBit;
      end
      if (installWe_i) begin
        validQ[victimWay_o][index_i] <= 1'b1;
        dirtyQ[victimWay_o][index_i] <= 1'b0;
      end else if (storeWe_i && hit_o) begin
        dirtyQ[hitWay_o][index_i] <= 1'b1;
      end
    end
  end

  // a tag lives in at most one way of a set
  aOneWayHit: assert property (@(posedge clk) disable iff (!rst_n)
    !(wayHit[0] && wayHit[1]));

endmodule

// File: verilog/dcacheDataArray.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcacheDataArray (
  input  logic                     clk,
  input  dcachePkg::index_t        index_i,
  input  logic [`DC_OFFSET_W-1:0]  offset_i,
  input  logic                     storeWe_i,
  input  logic                     storeWay_i,
  input  dcachePkg::word_t         wrData_i,
  input  dcachePkg::byteMask_t     wrMask_i,
  input  logic                     installWe_i,
  input  logic                     installWay_i,
  input  dcachePkg::line_t         installLine_i,
  output dcachePkg::line_t         way0Line_o,
  output dcachePkg::line_t         way1Line_o
);
  import dcachePkg::*;

  word_t     wordData;
  byteMask_t wordMask;
  word_t     wordBits;
  line_t     storeData;
  line_t     storeBits;

  // align the store to its byte lane, then to its word in the line
  always_comb begin
    wordData = wrData_i << {offset_i[2:0], 3'b000};
    wordMask = wrMask_i << offset_i[2:0];
    for (int b = 0; b < `DC_XLEN / 8; b++) begin
      wordBits[b*8 +: 8] = {8{wordMask[b]}};
    end
    storeData = line_t'(wordData) << {offset_i[`DC_OFFSET_W-1:3], 6'b000000};
    storeBits = line_t'(wordBits) << {offset_i[`DC_OFFSET_W-1:3], 6'b000000};
  end

  for (genvar w = 0; w < 2; w++) begin : gWay
    line_t mem [`DC_SETS];
    line_t lineQ;
    line_t nextLine;
    logic  installHere;
    logic  storeHere;

    assign installHere = installWe_i && (installWay_i == 1'(w));
    assign storeHere   = storeWe_i && (storeWay_i == 1'(w));

    // store merges into the stored line, install replaces it
    assign nextLine = installHere ? installLine_i
                                  : (mem[index_i] & ~storeBits) | (storeData & storeBits);

    // registered read, a write shows up on the output at once
    always_ff @(posedge clk) begin
      if (installHere || storeHere) begin
        mem[index_i] <= nextLine;
        lineQ        <= nextLine;
      end else begin
        lineQ <= mem[index_i];
      end
    end
  end

  assign way0Line_o = gWay[0].lineQ;
  assign way1Line_o = gWay[1].lineQ;

endmodule

// File: verilog/dcacheRefill.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcacheRefill (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  refillEn_i,
  input  dcachePkg::memRdResp_t memRdResp_i,
  output logic                  lineDone_o,
  output dcachePkg::line_t      refillLine_o
);
  import dcachePkg::*;

  localparam int BeatIdxW = $clog2(`DC_BEATS);

  logic [BeatIdxW-1:0] beatCnt;
  line_t               lineBuf;
  logic                beatTake;

  assign beatTake = refillEn_i && memRdResp_i.valid;

  // counter restarts for every refill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (!refillEn_i) begin
      beatCnt <= '0;
    end else if (memRdResp_i.valid) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  // beat n goes to word n of the line
  always_ff @(posedge clk) begin
    if (beatTake) begin
      lineBuf[beatCnt*`DC_XLEN +: `DC_XLEN] <= memRdResp_i.data;
    end
  end

  assign lineDone_o   = beatTake && memRdResp_i.last;
  assign refillLine_o = lineBuf;

  // memory must send exactly the beats of one line
  aLastBeat: assert property (@(posedge clk) disable iff (!rst_n)
    beatTake |-> (memRdResp_i.last == (beatCnt == BeatIdxW'(`DC_BEATS - 1))));

endmodule

// File: verilog/dcacheCtrl.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcacheCtrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  reqValid_i,
  input  dcachePkg::cpuReq_t    cpuReq_i,
  output logic                  addrOk_o,
  output logic                  dataOk_o,
  output dcachePkg::word_t      rdData_o,
  input  logic                  hit_i,
  input  logic                  hitWay_i,
  input  logic                  victimWay_i,
  input  dcachePkg::tag_t       victimTag_i,
  input  logic                  victimDirty_i,
  input  dcachePkg::line_t      way0Line_i,
  input  dcachePkg::line_t      way1Line_i,
  input  logic                  lineDone_i,
  output dcachePkg::cpuReq_t    reqLatch_o,
  output dcachePkg::index_t     readIndex_o,
  output logic                  storeWe_o,
  output logic                  installWe_o,
  output logic                  refillEn_o,
  output logic                  missSeen_o,
  output dcachePkg::memRdReq_t  memRdReq_o,
  input  logic                  memRdReady_i,
  output dcachePkg::memWrReq_t  memWrReq_o,
  input  logic                  memWrReady_i
);
  import dcachePkg::*;

  cacheState_e stateQ;
  cacheState_e stateD;
  cpuReq_t     reqQ;
  tag_t        reqTag;
  index_t      reqIndex;
  line_t       hitLine;
  logic        accept;

  assign addrOk_o = (stateQ == idle);
  assign accept   = reqValid_i && addrOk_o;
  assign reqTag   = reqQ.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
  assign reqIndex = reqQ.addr[`DC_OFFSET_W +: `DC_INDEX_W];

  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ <= cpuReq_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= idle;
    end else begin
      stateQ <= stateD;
    end
  end

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      idle:       if (accept) stateD = lookup;
      lookup: begin
        if (hit_i) begin
          stateD = idle;
        end else if (victimDirty_i) begin
          stateD = writeBack;
        end else begin
          stateD = refillReq;
        end
      end
      writeBack:  if (memWrReady_i) stateD = refillReq;
      refillReq:  if (memRdReady_i) stateD = refillWait;
      refillWait: if (lineDone_i) stateD = install;
      install:    stateD = lookup;
      default:    stateD = idle;
    endcase
  end

  // the data array reads ahead in idle so a hit costs one cycle
  assign readIndex_o = (stateQ == idle) ? cpuReq_i.addr[`DC_OFFSET_W +: `DC_INDEX_W]
                                        : reqIndex;
  assign reqLatch_o  = reqQ;
  assign dataOk_o    = (stateQ == lookup) && hit_i;
  assign missSeen_o  = (stateQ == lookup) && !hit_i;
  assign storeWe_o   = dataOk_o && reqQ.isStore;
  assign installWe_o = (stateQ == install);
  assign refillEn_o  = (stateQ == refillWait);

  // load word picked by offset bits 4:3
  assign hitLine  = hitWay_i ? way1Line_i : way0Line_i;
  assign rdData_o = hitLine[reqQ.addr[4:3]*`DC_XLEN +: `DC_XLEN];

  assign memRdReq_o.valid = (stateQ == refillReq);
  assign memRdReq_o.addr  = {reqTag, reqIndex, {`DC_OFFSET_W{1'b0}}};

  // victim line goes back to the address it was filled from
  assign memWrReq_o.valid = (stateQ == writeBack);
  assign memWrReq_o.addr  = {victimTag_i, reqIndex, {`DC_OFFSET_W{1'b0}}};
  assign memWrReq_o.data  = victimWay_i ? way1Line_i : way0Line_i;

  // a freshly installed line hits on the repeated lookup
  aInstallHit: assert property (@(posedge clk) disable iff (!rst_n)
    stateQ == install |=> hit_i);

  aWrHold: assert property (@(posedge clk) disable iff (!rst_n)
    memWrReq_o.valid && !memWrReady_i |=> memWrReq_o.valid && $stable(memWrReq_o));

endmodule

// File: verilog/dcacheTop.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcacheTop (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  reqValid_i,
  input  dcachePkg::cpuReq_t    cpuReq_i,
  output logic                  addrOk_o,
  output logic                  dataOk_o,
  output dcachePkg::word_t      rdData_o,
  output dcachePkg::memRdReq_t  memRdReq_o,
  input  logic                  memRdReady_i,
  input  dcachePkg::memRdResp_t memRdResp_i,
  output dcachePkg::memWrReq_t  memWrReq_o,
  input  logic                  memWrReady_i
);
  import dcachePkg::*;

  logic    hit;
  logic    hitWay;
  logic    victimWay;
  tag_t    victimTag;
  logic    victimDirty;
  line_t   way0Line;
  line_t   way1Line;
  logic    lineDone;
  line_t   refillLine;
  cpuReq_t reqLatch;
  index_t  readIndex;
  logic    storeWe;
  logic    installWe;
  logic    refillEn;
  logic    missSeen;

  dcacheCtrl u_ctrl (
    .clk, .rst_n, .reqValid_i, .cpuReq_i, .addrOk_o, .dataOk_o, .rdData_o,
    .hit_i(hit), .hitWay_i(hitWay), .victimWay_i(victimWay),
    .victimTag_i(victimTag), .victimDirty_i(victimDirty),
    .way0Line_i(way0Line), .way1Line_i(way1Line), .lineDone_i(lineDone),
    .reqLatch_o(reqLatch), .readIndex_o(readIndex), .storeWe_o(storeWe),
    .installWe_o(installWe), .refillEn_o(refillEn), .missSeen_o(missSeen),
    .memRdReq_o, .memRdReady_i, .memWrReq_o, .memWrReady_i
  );

  // tags compare against the latched request
  dcacheTagArray u_tags (
    .clk, .rst_n, .index_i(readIndex), .tag_i(reqLatch.addr[`DC_ADDR_W-1 -: `DC_TAG_W]),
    .storeWe_i(storeWe), .installWe_i(installWe), .missSeen_i(missSeen),
    .hit_o(hit), .hitWay_o(hitWay), .victimWay_o(victimWay),
    .victimTag_o(victimTag), .victimDirty_o(victimDirty)
  );

  dcacheDataArray u_data (
    .clk, .index_i(readIndex), .offset_i(reqLatch.addr[`DC_OFFSET_W-1:0]),
    .storeWe_i(storeWe), .storeWay_i(hitWay), .wrData_i(reqLatch.wrData),
    .wrMask_i(reqLatch.wrMask), .installWe_i(installWe), .installWay_i(victimWay),
    .installLine_i(refillLine), .way0Line_o(way0Line), .way1Line_o(way1Line)
  );

  dcacheRefill u_refill (
    .clk, .rst_n, .refillEn_i(refillEn), .memRdResp_i,
    .lineDone_o(lineDone), .refillLine_o(refillLine)
  );

endmodule

// File: verification/dcacheChecker.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcacheChecker (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  reqValid_i,
  input  dcachePkg::cpuReq_t    cpuReq_i,
  input  logic                  addrOk_i,
  input  logic                  dataOk_i,
  input  dcachePkg::word_t      rdData_i,
  input  dcachePkg::memRdReq_t  memRdReq_i,
  input  logic                  memRdReady_i,
  input  dcachePkg::memWrReq_t  memWrReq_i,
  input  logic                  memWrReady_i,
  input  dcachePkg::word_t      expData_i,
  input  logic                  expHit_i,
  input  dcachePkg::addr_t      expWbAddr_i,
  output int                    errCount_o,
  output int                    checkCount_o
);
  import dcachePkg::*;

  localparam addr_t NoWb = 32'hffff_ffff;

  cpuReq_t   curReq;
  word_t     curExp;
  logic      curHit;
  addr_t     curWb;
  logic      busy;
  int        age;
  logic      wbSeen;
  logic      rdSeen;
  memRdReq_t rdPrev;
  logic      rdReadyPrev;
  memWrReq_t wrPrev;
  logic      wrReadyPrev;
  addr_t     lineAddr;

  always @(posedge clk) begin
    if (!rst_n) begin
      errCount_o   = 0;
      checkCount_o = 0;
      busy         = 1'b0;
      age          = 0;
      rdPrev       = '0;
      wrPrev       = '0;
      rdReadyPrev  = 1'b0;
      wrReadyPrev  = 1'b0;
    end else begin
      // the cache is open for a request exactly when none is in flight
      if (addrOk_i == busy) begin
        $display("error at %0t ns: addrOk is %b with a request in flight %b",
                 $time, addrOk_i, busy);
        errCount_o++;
      end

      // a pending request must stay put until its ready
      if (rdPrev.valid && !rdReadyPrev) begin
        if (!memRdReq_i.valid || memRdReq_i.addr != rdPrev.addr) begin
          $display("error at %0t ns: read request dropped or changed before ready", $time);
          errCount_o++;
        end
      end
      if (wrPrev.valid && !wrReadyPrev && memWrReq_i != wrPrev) begin
        $display("error at %0t ns: write-back dropped or changed before ready", $time);
        errCount_o++;
      end

      if (busy) begin
        age++;
      end
      lineAddr = {curReq.addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};

      if (memWrReq_i.valid && memWrReady_i) begin
        $display("%0t ns: write-back of line %h", $time, memWrReq_i.addr);
        checkCount_o++;
        if (!busy || curWb == NoWb || memWrReq_i.addr != curWb) begin
          $display("error at %0t ns: write-back address %h, expected %h",
                   $time, memWrReq_i.addr, curWb);
          errCount_o++;
        end
        if (rdSeen) begin
          $display("error at %0t ns: write-back came after the refill read", $time);
          errCount_o++;
        end
        wbSeen = 1'b1;
      end

      if (memRdReq_i.valid && memRdReady_i) begin
        $display("%0t ns: refill read of line %h", $time, memRdReq_i.addr);
        checkCount_o++;
        if (!busy || memRdReq_i.addr != lineAddr) begin
          $display("error at %0t ns: refill address %h, expected %h",
                   $time, memRdReq_i.addr, lineAddr);
          errCount_o++;
        end
        if (curWb != NoWb && !wbSeen) begin
          $display("error at %0t ns: refill read before the dirty line went back", $time);
          errCount_o++;
        end
        rdSeen = 1'b1;
      end

      if (dataOk_i) begin
        checkCount_o++;
        if (!busy) begin
          $display("error at %0t ns: dataOk with no request in flight", $time);
          errCount_o++;
        end else begin
          if (curHit && age != 1) begin
            $display("error at %0t ns: hit took %0d cycles", $time, age);
            errCount_o++;
          end
          if (!curHit && !rdSeen) begin
            $display("error at %0t ns: miss on %h completed without a refill read",
                     $time, curReq.addr);
            errCount_o++;
          end
          if (curWb != NoWb && !wbSeen) begin
            $display("error at %0t ns: expected write-back of %h never seen", $time, curWb);
            errCount_o++;
          end
          if (!curReq.isStore && rdData_i != curExp) begin
            $display("error at %0t ns: load %h returned %h, expected %h",
                     $time, curReq.addr, rdData_i, curExp);
            errCount_o++;
          end
          busy = 1'b0;
        end
      end

      // capture what the file expects for the accepted request
      if (reqValid_i && addrOk_i) begin
        busy   = 1'b1;
        age    = 0;
        curReq = cpuReq_i;
        curExp = expData_i;
        curHit = expHit_i;
        curWb  = expWbAddr_i;
        wbSeen = 1'b0;
        rdSeen = 1'b0;
      end

      rdPrev      = memRdReq_i;
      rdReadyPrev = memRdReady_i;
      wrPrev      = memWrReq_i;
      wrReadyPrev = memWrReady_i;
    end
  end

endmodule

// File: verification/dcacheTb.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcacheTb;
  import dcachePkg::*;

  localparam int WaitLimit = 400;

  logic       clk;
  logic       rst_n;
  logic       reqValid;
  cpuReq_t    cpuReq;
  logic       addrOk;
  logic       dataOk;
  word_t      rdData;
  memRdReq_t  memRdReq;
  logic       memRdReady;
  memRdResp_t memRdResp;
  memWrReq_t  memWrReq;
  logic       memWrReady;
  word_t      expData;
  logic       expHit;
  addr_t      expWbAddr;
  int         errCount;
  int         checkCount;

  // memory model, words written back so far
  word_t memModel [addr_t];
  logic  rdActive;
  int    rdBeat;
  addr_t rdAddr;

  dcacheTop u_dut (
    .clk, .rst_n, .reqValid_i(reqValid), .cpuReq_i(cpuReq), .addrOk_o(addrOk),
    .dataOk_o(dataOk), .rdData_o(rdData), .memRdReq_o(memRdReq),
    .memRdReady_i(memRdReady), .memRdResp_i(memRdResp), .memWrReq_o(memWrReq),
    .memWrReady_i(memWrReady)
  );

  dcacheChecker u_chk (
    .clk, .rst_n, .reqValid_i(reqValid), .cpuReq_i(cpuReq), .addrOk_i(addrOk),
    .dataOk_i(dataOk), .rdData_i(rdData), .memRdReq_i(memRdReq),
    .memRdReady_i(memRdReady), .memWrReq_i(memWrReq), .memWrReady_i(memWrReady),
    .expData_i(expData), .expHit_i(expHit), .expWbAddr_i(expWbAddr),
    .errCount_o(errCount), .checkCount_o(checkCount)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // untouched words hold the address over its inverse
  function automatic word_t readWord(input addr_t a);
    addr_t wa;
    wa = {a[`DC_ADDR_W-1:3], 3'b000};
    if (memModel.exists(wa)) begin
      return memModel[wa];
    end
    return {wa, ~wa};
  endfunction

  always @(posedge clk) begin
    if (rst_n) begin
      memRdReady <= ($urandom % 4) == 0;
      memWrReady <= ($urandom % 4) == 0;
      if (memWrReq.valid && memWrReady) begin
        for (int b = 0; b < `DC_BEATS; b++) begin
          memModel[memWrReq.addr + addr_t'(b * 8)] = memWrReq.data[b*`DC_XLEN +: `DC_XLEN];
        end
      end
      memRdResp.valid <= 1'b0;
      memRdResp.last  <= 1'b0;
      // beats come with random gaps
      if (rdActive && ($urandom % 3) != 0) begin
        memRdResp.valid <= 1'b1;
        memRdResp.last  <= (rdBeat == `DC_BEATS - 1);
        memRdResp.data  <= readWord(rdAddr + addr_t'(rdBeat * 8));
        rdBeat          <= rdBeat + 1;
        if (rdBeat == `DC_BEATS - 1) begin
          rdActive <= 1'b0;
        end
      end
      if (memRdReq.valid && memRdReady) begin
        rdActive <= 1'b1;
        rdBeat   <= 0;
        rdAddr   <= memRdReq.addr;
      end
    end
  end

  task automatic runRequest(input logic isStore, input addr_t addr, input word_t wdata,
                            input byteMask_t mask, input word_t exp, input logic hitFlag,
                            input addr_t wb, output logic timedOut);
    int cycles;
    timedOut = 1'b0;
    @(posedge clk);
    reqValid  <= 1'b1;
    cpuReq    <= '{isStore, addr, wdata, mask};
    expData   <= exp;
    expHit    <= hitFlag;
    expWbAddr <= wb;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!addrOk && cycles < WaitLimit);
    reqValid <= 1'b0;
    if (cycles >= WaitLimit) begin
      $display("timed out waiting for the cache to accept address %h", addr);
      timedOut = 1'b1;
    end else begin
      cycles = 0;
      do begin
        @(posedge clk);
        cycles++;
      end while (!dataOk && cycles < WaitLimit);
      if (cycles >= WaitLimit) begin
        $display("timed out waiting for completion of address %h", addr);
        timedOut = 1'b1;
      end
    end
  endtask

  initial begin
    int        fd;
    int        n;
    string     line;
    string     op;
    addr_t     addr;
    word_t     wdata;
    byteMask_t mask;
    word_t     exp;
    int        hitNum;
    addr_t     wb;
    logic      stopped;
    void'($urandom(32'h330b));
    rst_n      <= 1'b0;
    reqValid   <= 1'b0;
    cpuReq     <= '0;
    memRdReady <= 1'b0;
    memWrReady <= 1'b0;
    memRdResp  <= '0;
    expData    <= '0;
    expHit     <= 1'b0;
    expWbAddr  <= '1;
    rdActive   <= 1'b0;
    rdBeat     <= 0;
    rdAddr     <= '0;
    stopped    = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    fd = $fopen("verification/dcache_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file verification/dcache_stimulus.txt");
      stopped = 1'b1;
    end else begin
      while (!$feof(fd) && !stopped) begin
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %h %h %h %h %d %h", op, addr, wdata, mask, exp, hitNum, wb);
          if (n == 7) begin
            runRequest(op == "S", addr, wdata, mask, exp, hitNum != 0, wb, stopped);
          end
        end
      end
      $fclose(fd);
    end
    repeat (2) @(posedge clk);
    $display("checks: %0d  errors: %0d", checkCount, errCount);
    if (!stopped && errCount == 0 && checkCount > 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: dcacheTop.f
+incdir+include
verilog/dcachePkg.sv
verilog/dcacheTagArray.sv
verilog/dcacheDataArray.sv
verilog/dcacheRefill.sv
verilog/dcacheCtrl.sv
verilog/dcacheTop.sv
verification/dcacheChecker.sv
verification/dcacheTb.sv

// File: run.sh
#!/bin/sh
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  -f dcacheTop.f \
  --top-module dcacheTb \
  --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$LOG"
  echo "simulation exited with an error"
  exit 1
fi

cat "$LOG"
if grep -q "TEST RESULT: PASS" "$LOG"; then
  exit 0
fi
exit 1

// File: verification/dcache_stimulus.txt
# op (L load, S store) address store-data byte-mask expected-load-data hit write-back-line
# hit 1 means one cycle from accept to dataOk, write-back ffffffff means none
# set 1, first touch then hits and a partial store
L 00000020 0000000000000000 00 00000020ffffffdf 0 ffffffff
L 00000028 0000000000000000 00 00000028ffffffd7 1 ffffffff
S 0000002c 1122334455667788 0f 0000000000000000 1 ffffffff
L 00000028 0000000000000000 00 55667788ffffffd7 1 ffffffff
# third tag on set 1 pushes the dirty line out
L 00000820 0000000000000000 00 00000820fffff7df 0 ffffffff
L 00001030 0000000000000000 00 00001030ffffefcf 0 00000020
L 0000002c 0000000000000000 00 55667788ffffffd7 0 ffffffff
# store miss, then evict and reload it
S 00000838 aabbccdd00112233 03 0000000000000000 0 ffffffff
L 00000838 0000000000000000 00 00000838ffff2233 1 ffffffff
L 00001020 0000000000000000 00 00001020ffffefdf 0 ffffffff
L 00000020 0000000000000000 00 00000020ffffffdf 0 00000820
L 00000838 0000000000000000 00 00000838ffff2233 0 ffffffff
# set 2
S 00000040 0123456789abcdef ff 0000000000000000 0 ffffffff
L 00000040 0000000000000000 00 0123456789abcdef 1 ffffffff
L 00000058 0000000000000000 00 00000058ffffffa7 1 ffffffff
S 0000005a 000000000000beef 03 0000000000000000 1 ffffffff
L 00000058 0000000000000000 00 00000058beefffa7 1 ffffffff
L 00000848 0000000000000000 00 00000848fffff7b7 0 ffffffff
L 00001040 0000000000000000 00 00001040ffffefbf 0 00000040
L 00000058 0000000000000000 00 00000058beefffa7 0 ffffffff
L 00000040 0000000000000000 00 0123456789abcdef 1 ffffffff
# set 3
L 00000078 0000000000000000 00 00000078ffffff87 0 ffffffff
L 00000060 0000000000000000 00 00000060ffffff9f 1 ffffffff
# set 1 lines still resident
L 00000028 0000000000000000 00 55667788ffffffd7 1 ffffffff
L 00000830 0000000000000000 00 00000830fffff7cf 1 ffffffff
